// ==== logic/v850_defines.svh ====
`ifndef V850_DEFINES_SVH
`define V850_DEFINES_SVH

// Data path and general register width
`define V850_XLEN        32

// General register count, r0 included
`define V850_NREG        32
`define V850_REG_BITS    5   // reg1/reg2 field width

// Opcode field, word bits 10:5
`define V850_OPCODE_BITS 6

// Format II short immediate
`define V850_IMM5_BITS   5

`endif

// ==== logic/v850_isa_pkg.sv ====
`include "v850_defines.svh"

package v850_isa_pkg;

    // Supported 16-bit opcodes, word bits 10:5
    typedef enum logic [`V850_OPCODE_BITS-1:0] {
        op_mov     = 6'b000000,  // MOV reg1, reg2
        op_not     = 6'b000001,
        op_or      = 6'b001000,
        op_xor     = 6'b001001,
        op_and     = 6'b001010,
        op_tst     = 6'b001011,  // AND without write-back
        op_subr    = 6'b001100,  // reg1 - reg2
        op_sub     = 6'b001101,
        op_add     = 6'b001110,
        op_cmp     = 6'b001111,  // SUB without write-back
        op_mov_imm = 6'b010000,  // Sign-extended imm5
        op_add_imm = 6'b010010,
        op_cmp_imm = 6'b010011,
        op_shr_imm = 6'b010100,  // Zero-extended shift count
        op_sar_imm = 6'b010101,
        op_shl_imm = 6'b010110
    } opcode_e;

    // Format I, rrrrr oooooo RRRRR
    typedef struct packed {
        logic [`V850_REG_BITS-1:0]  reg2;
        opcode_e                    opcode;
        logic [`V850_REG_BITS-1:0]  reg1;
    } fmt1_t;

    // Format II, rrrrr oooooo iiiii
    typedef struct packed {
        logic [`V850_REG_BITS-1:0]  reg2;
        opcode_e                    opcode;
        logic [`V850_IMM5_BITS-1:0] imm5;
    } fmt2_t;

    // Low five bits are reg1 or imm5 depending on opcode
    typedef union packed {
        fmt1_t fmt1;
        fmt2_t fmt2;
    } insn_u;

endpackage

// ==== logic/v850_core_pkg.sv ====
`include "v850_defines.svh"

package v850_core_pkg;

    // Execute stage operation, result is reg2 op A
    typedef enum logic [3:0] {
        alu_pass,   // MOV, A straight through
        alu_not,
        alu_or,
        alu_xor,
        alu_and,
        alu_add,
        alu_sub,    // reg2 - A
        alu_subr,   // A - reg2
        alu_shr,
        alu_sar,
        alu_shl,
        alu_nop     // Unsupported opcode
    } alu_op_e;

    // PSW low nibble, same bit order as the V850 PSW
    typedef struct packed {
        logic cy;
        logic ov;
        logic s;
        logic z;
    } flags_t;

    // One record per accepted instruction
    typedef struct packed {
        logic [`V850_REG_BITS-1:0] dest;
        logic                      write;  // Register actually written
        logic [`V850_XLEN-1:0]     data;
        flags_t                    flags;  // PSW after this instruction
    } retire_t;

endpackage

// ==== logic/v850_ifs.sv ====
`timescale 1ns/1ps
`include "v850_defines.svh"

// Decoded instruction, decode register to execute
interface issue_if;
    logic                      valid;
    logic                      ready;
    v850_core_pkg::alu_op_e    alu_op;
    logic [`V850_XLEN-1:0]     op_a;          // reg1 data or extended imm5
    logic [`V850_XLEN-1:0]     op_b;          // reg2 data
    logic [`V850_REG_BITS-1:0] dest;          // Always the reg2 field
    logic                      writes_reg;
    logic                      writes_flags;

    modport dec (
        output valid,
        output alu_op,
        output op_a,
        output op_b,
        output dest,
        output writes_reg,
        output writes_flags,
        input  ready
    );

    modport exe (
        input  valid,
        input  alu_op,
        input  op_a,
        input  op_b,
        input  dest,
        input  writes_reg,
        input  writes_flags,
        output ready
    );
endinterface

// Write-back of the current edge, forwarded to operand read
interface bypass_if;
    logic                      fire;   // Issue transfer this edge
    logic [`V850_REG_BITS-1:0] dest;
    logic                      write;
    logic [`V850_XLEN-1:0]     data;

    modport src (
        output fire,
        output dest,
        output write,
        output data
    );

    modport snk (
        input  fire,
        input  dest,
        input  write,
        input  data
    );
endinterface

// ==== logic/v850_regfile.sv ====
`timescale 1ns/1ps
`include "v850_defines.svh"

module v850_regfile (
    input  logic                      clk,
    input  logic                      reset,
    input  logic [`V850_REG_BITS-1:0] rd_a_idx,   // reg1 port
    input  logic [`V850_REG_BITS-1:0] rd_b_idx,   // reg2 port
    output logic [`V850_XLEN-1:0]     rd_a_data,
    output logic [`V850_XLEN-1:0]     rd_b_data,
    input  logic                      wr_en,
    input  logic [`V850_REG_BITS-1:0] wr_idx,
    input  logic [`V850_XLEN-1:0]     wr_data
);

    // General registers r0..r31
    logic [`V850_XLEN-1:0] regs [`V850_NREG];

    // Combinational reads, r0 forced to zero
    assign rd_a_data = (rd_a_idx == '0) ? '0 : regs[rd_a_idx];
    assign rd_b_data = (rd_b_idx == '0) ? '0 : regs[rd_b_idx];

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < `V850_NREG; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en && wr_idx != '0) begin  // Writes to r0 dropped
            regs[wr_idx] <= wr_data;
        end
    end

endmodule

// ==== logic/v850_decoder.sv ====
`timescale 1ns/1ps
`include "v850_defines.svh"

module v850_decoder (
    input  logic                      clk,
    input  logic                      reset,
    input  logic                      in_valid,
    output logic                      in_ready,
    input  v850_isa_pkg::insn_u       in_insn,
    output logic [`V850_REG_BITS-1:0] rd_a_idx,
    output logic [`V850_REG_BITS-1:0] rd_b_idx,
    input  logic [`V850_XLEN-1:0]     rd_a_data,
    input  logic [`V850_XLEN-1:0]     rd_b_data,
    issue_if.dec                      issue,
    bypass_if.snk                     bypass
);

    v850_isa_pkg::opcode_e  opcode;
    v850_core_pkg::alu_op_e alu_op;
    logic                   imm_sext;     // MOV/ADD/CMP imm5
    logic                   imm_zext;     // Shift counts
    logic                   no_write;     // CMP and TST
    logic                   writes_reg;
    logic                   writes_flags;
    logic                   fwd_a;
    logic                   fwd_b;
    logic [`V850_XLEN-1:0]  reg1_val;
    logic [`V850_XLEN-1:0]  reg2_val;
    logic [`V850_XLEN-1:0]  op_a;
    logic                   accept;

    assign opcode   = in_insn.fmt1.opcode;
    assign rd_a_idx = in_insn.fmt1.reg1;
    assign rd_b_idx = in_insn.fmt1.reg2;

    // Forward execute's write of this same edge, never for r0
    assign fwd_a = bypass.fire && bypass.write && bypass.dest == rd_a_idx && rd_a_idx != '0;
    assign fwd_b = bypass.fire && bypass.write && bypass.dest == rd_b_idx && rd_b_idx != '0;
    assign reg1_val = fwd_a ? bypass.data : rd_a_data;
    assign reg2_val = fwd_b ? bypass.data : rd_b_data;

    always_comb begin
        case (opcode)
            v850_isa_pkg::op_mov,
            v850_isa_pkg::op_mov_imm: alu_op = v850_core_pkg::alu_pass;
            v850_isa_pkg::op_not:     alu_op = v850_core_pkg::alu_not;
            v850_isa_pkg::op_or:      alu_op = v850_core_pkg::alu_or;
            v850_isa_pkg::op_xor:     alu_op = v850_core_pkg::alu_xor;
            v850_isa_pkg::op_and,
            v850_isa_pkg::op_tst:     alu_op = v850_core_pkg::alu_and;
            v850_isa_pkg::op_subr:    alu_op = v850_core_pkg::alu_subr;
            v850_isa_pkg::op_sub,
            v850_isa_pkg::op_cmp,
            v850_isa_pkg::op_cmp_imm: alu_op = v850_core_pkg::alu_sub;
            v850_isa_pkg::op_add,
            v850_isa_pkg::op_add_imm: alu_op = v850_core_pkg::alu_add;
            v850_isa_pkg::op_shr_imm: alu_op = v850_core_pkg::alu_shr;
            v850_isa_pkg::op_sar_imm: alu_op = v850_core_pkg::alu_sar;
            v850_isa_pkg::op_shl_imm: alu_op = v850_core_pkg::alu_shl;
            default:                  alu_op = v850_core_pkg::alu_nop;  // Retires as no-op
        endcase
    end

    assign imm_sext = opcode inside {v850_isa_pkg::op_mov_imm, v850_isa_pkg::op_add_imm,
                                     v850_isa_pkg::op_cmp_imm};
    assign imm_zext = opcode inside {v850_isa_pkg::op_shr_imm, v850_isa_pkg::op_sar_imm,
                                     v850_isa_pkg::op_shl_imm};
    assign no_write = opcode inside {v850_isa_pkg::op_cmp, v850_isa_pkg::op_cmp_imm,
                                     v850_isa_pkg::op_tst};

    // Unknown opcodes decode to nop and touch nothing
    assign writes_reg = alu_op != v850_core_pkg::alu_nop && !no_write
                        && in_insn.fmt2.reg2 != '0;
    assign writes_flags = alu_op != v850_core_pkg::alu_nop
                          && !(opcode inside {v850_isa_pkg::op_mov, v850_isa_pkg::op_mov_imm});

    // Operand A, same low field seen as register or immediate
    always_comb begin
        if (imm_sext) begin
            op_a = {{(`V850_XLEN-`V850_IMM5_BITS){in_insn.fmt2.imm5[`V850_IMM5_BITS-1]}},
                    in_insn.fmt2.imm5};
        end else if (imm_zext) begin
            op_a = {{(`V850_XLEN-`V850_IMM5_BITS){1'b0}}, in_insn.fmt2.imm5};
        end else begin
            op_a = reg1_val;
        end
    end

    // Take a new word when empty or draining into execute
    assign in_ready = !issue.valid || issue.ready;
    assign accept   = in_valid && in_ready;

    always_ff @(posedge clk) begin
        if (reset) begin
            issue.valid <= 1'b0;
        end else if (accept) begin
            issue.valid <= 1'b1;
        end else if (issue.ready) begin
            issue.valid <= 1'b0;  // Handed to execute, nothing behind it
        end
    end

    // Decode register payload
    always_ff @(posedge clk) begin
        if (accept) begin
            issue.alu_op       <= alu_op;
            issue.op_a         <= op_a;
            issue.op_b         <= reg2_val;
            issue.dest         <= in_insn.fmt1.reg2;
            issue.writes_reg   <= writes_reg;
            issue.writes_flags <= writes_flags;
        end
    end

endmodule

// ==== logic/v850_execute.sv ====
`timescale 1ns/1ps
`include "v850_defines.svh"

module v850_execute (
    input  logic                      clk,
    input  logic                      reset,
    issue_if.exe                      issue,
    bypass_if.src                     bypass,
    output logic                      wr_en,
    output logic [`V850_REG_BITS-1:0] wr_idx,
    output logic [`V850_XLEN-1:0]     wr_data,
    output logic                      out_valid,
    input  logic                      out_ready,
    output v850_core_pkg::retire_t    out_retire
);

    localparam int MSB = `V850_XLEN - 1;

    v850_core_pkg::flags_t   psw;
    v850_core_pkg::flags_t   psw_next;
    logic                    fire;
    logic [`V850_XLEN-1:0]   result;
    logic                    cy_new;
    logic                    ov_new;
    logic [`V850_XLEN-1:0]   add_x;
    logic [`V850_XLEN-1:0]   add_y;
    logic [`V850_XLEN-1:0]   add_y_eff;
    logic                    add_sub;
    logic [`V850_XLEN:0]     add_sum;
    logic                    add_cy;
    logic                    add_ov;
    logic [4:0]              shamt;
    logic [`V850_XLEN:0]     shl_full;   // Carry out on top
    logic [`V850_XLEN:0]     shr_full;   // Carry out at bit 0
    logic [`V850_XLEN:0]     sar_full;

    // One adder for ADD, SUB and SUBR
    always_comb begin
        add_x   = issue.op_b;
        add_y   = issue.op_a;
        add_sub = 1'b0;
        case (issue.alu_op)
            v850_core_pkg::alu_sub: add_sub = 1'b1;
            v850_core_pkg::alu_subr: begin  // Operands swapped
                add_x   = issue.op_a;
                add_y   = issue.op_b;
                add_sub = 1'b1;
            end
            default: add_sub = 1'b0;
        endcase
    end

    assign add_y_eff = add_sub ? ~add_y : add_y;
    assign add_sum   = {1'b0, add_x} + {1'b0, add_y_eff} + {{`V850_XLEN{1'b0}}, add_sub};
    assign add_cy    = add_sum[`V850_XLEN] ^ add_sub;  // Borrow when subtracting
    assign add_ov    = (add_x[MSB] == add_y_eff[MSB]) && (add_sum[MSB] != add_x[MSB]);

    // Shifts carry an extra bit to catch the last one out, zero for count 0
    assign shamt    = issue.op_a[4:0];
    assign shl_full = {1'b0, issue.op_b} << shamt;
    assign shr_full = {issue.op_b, 1'b0} >> shamt;
    assign sar_full = $signed({issue.op_b, 1'b0}) >>> shamt;

    always_comb begin
        cy_new = psw.cy;  // Logic ops keep CY
        ov_new = 1'b0;
        case (issue.alu_op)
            v850_core_pkg::alu_pass: result = issue.op_a;
            v850_core_pkg::alu_not:  result = ~issue.op_a;
            v850_core_pkg::alu_or:   result = issue.op_b | issue.op_a;
            v850_core_pkg::alu_xor:  result = issue.op_b ^ issue.op_a;
            v850_core_pkg::alu_and:  result = issue.op_b & issue.op_a;
            v850_core_pkg::alu_add,
            v850_core_pkg::alu_sub,
            v850_core_pkg::alu_subr: begin
                result = add_sum[MSB:0];
                cy_new = add_cy;
                ov_new = add_ov;
            end
            v850_core_pkg::alu_shr: begin
                result = shr_full[`V850_XLEN:1];
                cy_new = shr_full[0];
            end
            v850_core_pkg::alu_sar: begin
                result = sar_full[`V850_XLEN:1];  // Sign fill from bit 31
                cy_new = sar_full[0];
            end
            v850_core_pkg::alu_shl: begin
                result = shl_full[MSB:0];
                cy_new = shl_full[`V850_XLEN];
            end
            default: result = '0;
        endcase

        psw_next = psw;
        if (issue.writes_flags) begin
            psw_next.cy = cy_new;
            psw_next.ov = ov_new;
            psw_next.s  = result[MSB];
            psw_next.z  = (result == '0);
        end
    end

    // Stall while the output register is full and not draining
    assign issue.ready = !out_valid || out_ready;
    assign fire        = issue.valid && issue.ready;

    // Register write-back, same edge as the retire load
    assign wr_en   = fire && issue.writes_reg;
    assign wr_idx  = issue.dest;
    assign wr_data = result;

    assign bypass.fire  = fire;
    assign bypass.dest  = issue.dest;
    assign bypass.write = issue.writes_reg;
    assign bypass.data  = result;

    always_ff @(posedge clk) begin
        if (reset) begin
            psw       <= '0;
            out_valid <= 1'b0;
        end else if (fire) begin
            psw       <= psw_next;
            out_valid <= 1'b1;
        end else if (out_ready) begin
            out_valid <= 1'b0;
        end
    end

    // Retirement record
    always_ff @(posedge clk) begin
        if (fire) begin
            out_retire.dest  <= issue.dest;
            out_retire.write <= issue.writes_reg;
            out_retire.data  <= result;
            out_retire.flags <= psw_next;
        end
    end

endmodule

// ==== logic/v850_core.sv ====
`timescale 1ns/1ps
`include "v850_defines.svh"

module v850_core (
    input  logic                      clk,
    input  logic                      reset,
    input  logic                      in_valid,
    output logic                      in_ready,
    input  logic [15:0]               in_insn,     // One 16-bit instruction word
    output logic                      out_valid,
    input  logic                      out_ready,
    output logic [`V850_REG_BITS-1:0] out_dest,
    output logic                      out_write,
    output logic [`V850_XLEN-1:0]     out_data,
    output logic [3:0]                out_flags    // CY OV S Z
);

    // Regfile read side, driven by decode
    logic [`V850_REG_BITS-1:0] rd_a_idx;
    logic [`V850_REG_BITS-1:0] rd_b_idx;
    logic [`V850_XLEN-1:0]     rd_a_data;
    logic [`V850_XLEN-1:0]     rd_b_data;

    // Write side, driven by execute
    logic                      wr_en;
    logic [`V850_REG_BITS-1:0] wr_idx;
    logic [`V850_XLEN-1:0]     wr_data;

    v850_core_pkg::retire_t    retire;

    issue_if  issue ();
    bypass_if bypass ();

    v850_regfile u_regfile (
        .clk       (clk),
        .reset     (reset),
        .rd_a_idx  (rd_a_idx),
        .rd_b_idx  (rd_b_idx),
        .rd_a_data (rd_a_data),
        .rd_b_data (rd_b_data),
        .wr_en     (wr_en),
        .wr_idx    (wr_idx),
        .wr_data   (wr_data)
    );

    v850_decoder u_decoder (
        .clk       (clk),
        .reset     (reset),
        .in_valid  (in_valid),
        .in_ready  (in_ready),
        .in_insn   (in_insn),
        .rd_a_idx  (rd_a_idx),
        .rd_b_idx  (rd_b_idx),
        .rd_a_data (rd_a_data),
        .rd_b_data (rd_b_data),
        .issue     (issue.dec),
        .bypass    (bypass.snk)
    );

    v850_execute u_execute (
        .clk        (clk),
        .reset      (reset),
        .issue      (issue.exe),
        .bypass     (bypass.src),
        .wr_en      (wr_en),
        .wr_idx     (wr_idx),
        .wr_data    (wr_data),
        .out_valid  (out_valid),
        .out_ready  (out_ready),
        .out_retire (retire)
    );

    // Flatten the record onto the output stream
    assign out_dest  = retire.dest;
    assign out_write = retire.write;
    assign out_data  = retire.data;
    assign out_flags = retire.flags;

endmodule

// ==== dv/v850_ref.svh ====
`ifndef V850_REF_SVH
`define V850_REF_SVH

// Architectural state, r0 is never written so it reads zero
logic [`V850_XLEN-1:0] model_regs [`V850_NREG];
v850_core_pkg::flags_t model_psw;

function automatic void model_clear();
    for (int i = 0; i < `V850_NREG; i++) begin
        model_regs[i] = '0;
    end
    model_psw = '0;
endfunction

// x + y, unsigned carry and signed overflow
function automatic logic [31:0] model_add(input logic [31:0] x, input logic [31:0] y,
                                          output logic cy, output logic ov);
    logic [32:0] sum;
    sum = {1'b0, x} + {1'b0, y};
    cy  = sum[32];
    ov  = (x[31] == y[31]) && (sum[31] != x[31]);
    return sum[31:0];
endfunction

// x - y, CY is the borrow
function automatic logic [31:0] model_sub(input logic [31:0] x, input logic [31:0] y,
                                          output logic cy, output logic ov);
    logic [31:0] diff;
    diff = x - y;
    cy   = (x < y);
    ov   = (x[31] != y[31]) && (diff[31] != x[31]);  // Operand signs differ, result flips
    return diff;
endfunction

// Expected record for one word, advances the model state
function automatic v850_core_pkg::retire_t predict_retire(input logic [15:0] word);
    logic [4:0]             r2;
    logic [5:0]             opc;
    logic [4:0]             low;
    logic [31:0]            a;
    logic [31:0]            b;
    logic [31:0]            imm;
    logic [31:0]            res;
    logic                   known;
    logic                   wr;
    logic                   fl;
    logic                   cy;
    logic                   ov;
    v850_core_pkg::retire_t rec;
    r2    = word[15:11];
    opc   = word[10:5];
    low   = word[4:0];
    a     = model_regs[low];       // reg1
    b     = model_regs[r2];        // reg2, also the destination
    imm   = {{27{low[4]}}, low};
    res   = '0;
    known = 1'b1;
    cy    = model_psw.cy;          // Kept by logic ops
    ov    = 1'b0;
    case (opc)
        v850_isa_pkg::op_mov:     res = a;
        v850_isa_pkg::op_not:     res = ~a;
        v850_isa_pkg::op_or:      res = b | a;
        v850_isa_pkg::op_xor:     res = b ^ a;
        v850_isa_pkg::op_and,
        v850_isa_pkg::op_tst:     res = b & a;
        v850_isa_pkg::op_subr:    res = model_sub(a, b, cy, ov);
        v850_isa_pkg::op_sub,
        v850_isa_pkg::op_cmp:     res = model_sub(b, a, cy, ov);
        v850_isa_pkg::op_add:     res = model_add(b, a, cy, ov);
        v850_isa_pkg::op_mov_imm: res = imm;
        v850_isa_pkg::op_add_imm: res = model_add(b, imm, cy, ov);
        v850_isa_pkg::op_cmp_imm: res = model_sub(b, imm, cy, ov);
        v850_isa_pkg::op_shr_imm: begin
            res = b >> low;
            cy  = (low == 5'd0) ? 1'b0 : b[low - 5'd1];
        end
        v850_isa_pkg::op_sar_imm: begin
            res = $signed(b) >>> low;
            cy  = (low == 5'd0) ? 1'b0 : b[low - 5'd1];
        end
        v850_isa_pkg::op_shl_imm: begin
            res = b << low;
            cy  = (low == 5'd0) ? 1'b0 : b[5'(32 - low)];
        end
        default:                  known = 1'b0;  // No-op
    endcase
    wr = known && r2 != 5'd0
         && !(opc inside {v850_isa_pkg::op_cmp, v850_isa_pkg::op_cmp_imm, v850_isa_pkg::op_tst});
    fl = known && !(opc inside {v850_isa_pkg::op_mov, v850_isa_pkg::op_mov_imm});
    if (wr) begin
        model_regs[r2] = res;
    end
    if (fl) begin
        model_psw.cy = cy;
        model_psw.ov = ov;
        model_psw.s  = res[31];
        model_psw.z  = (res == '0);
    end
    rec.dest  = r2;
    rec.write = wr;
    rec.data  = res;
    rec.flags = model_psw;
    return rec;
endfunction

`endif

// ==== dv/v850_tb.sv ====
`timescale 1ns/1ps
`include "v850_defines.svh"

module v850_tb;

    logic                      clk = 1'b0;
    logic                      reset;
    logic                      in_valid;
    logic                      in_ready;
    logic [15:0]               in_insn;
    logic                      out_valid;
    logic                      out_ready;
    logic [`V850_REG_BITS-1:0] out_dest;
    logic                      out_write;
    logic [`V850_XLEN-1:0]     out_data;
    logic [3:0]                out_flags;

    logic [31:0]            stim_seed;
    logic [31:0]            bp_seed;      // Separate stream for out_ready
    logic                   bp_enable;
    int                     check_count;
    int                     error_count;
    int                     test_checks;
    int                     test_errors;
    v850_core_pkg::retire_t expect_q[$];  // In program order

    logic [5:0] all_ops [16] = '{
        v850_isa_pkg::op_mov, v850_isa_pkg::op_not, v850_isa_pkg::op_or, v850_isa_pkg::op_xor,
        v850_isa_pkg::op_and, v850_isa_pkg::op_tst, v850_isa_pkg::op_subr, v850_isa_pkg::op_sub,
        v850_isa_pkg::op_add, v850_isa_pkg::op_cmp, v850_isa_pkg::op_mov_imm,
        v850_isa_pkg::op_add_imm, v850_isa_pkg::op_cmp_imm, v850_isa_pkg::op_shr_imm,
        v850_isa_pkg::op_sar_imm, v850_isa_pkg::op_shl_imm
    };
    logic [5:0] alu_ops [8] = '{
        v850_isa_pkg::op_add, v850_isa_pkg::op_sub, v850_isa_pkg::op_subr, v850_isa_pkg::op_and,
        v850_isa_pkg::op_or, v850_isa_pkg::op_xor, v850_isa_pkg::op_not, v850_isa_pkg::op_add
    };

    `include "v850_ref.svh"

    v850_core u_dut (
        .clk       (clk),
        .reset     (reset),
        .in_valid  (in_valid),
        .in_ready  (in_ready),
        .in_insn   (in_insn),
        .out_valid (out_valid),
        .out_ready (out_ready),
        .out_dest  (out_dest),
        .out_write (out_write),
        .out_data  (out_data),
        .out_flags (out_flags)
    );

    always #50 clk = ~clk;  // 100 ns period

    function automatic logic [31:0] lcg_step(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    function automatic logic [4:0] rand5();
        stim_seed = lcg_step(stim_seed);
        return stim_seed[28:24];  // High bits, better period
    endfunction

    function automatic logic [4:0] rand_reg_nz();
        logic [4:0] r;
        r = rand5();
        return (r == 5'd0) ? 5'd1 : r;
    endfunction

    function automatic logic [15:0] encode(input logic [4:0] reg2, input logic [5:0] opc,
                                           input logic [4:0] low);
        return {reg2, opc, low};
    endfunction

    // True for the sixteen implemented opcodes
    function automatic logic opcode_known(input logic [5:0] opc);
        logic hit;
        hit = 1'b0;
        for (int k = 0; k < 16; k++) begin
            if (all_ops[k] == opc) begin
                hit = 1'b1;
            end
        end
        return hit;
    endfunction

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] want);
        check_count++;
        if (got !== want) begin
            error_count++;
            $display("[ERROR] %s: got %h, expected %h", name, got, want);
        end
    endtask

    task automatic abort_run(input string what);
        $display("Timeout: %s", what);
        $display("Test FAILED");
        $finish;
    endtask

    // Entered and left a little after a rising edge
    task automatic send_insn(input logic [15:0] word);
        int   waited;
        logic taken;
        waited   = 0;
        taken    = 1'b0;
        in_valid = 1'b1;
        in_insn  = word;
        while (!taken) begin
            @(negedge clk);
            if (in_ready) begin  // Transfer on the coming edge
                expect_q.push_back(predict_retire(word));
                taken = 1'b1;
            end else if (waited >= 200) begin
                abort_run("instruction was never accepted");
            end
            waited++;
            @(posedge clk);
            #1;
        end
        in_valid = 1'b0;
    endtask

    // All records out, then a per-test line
    task automatic finish_test(input string name);
        int waited;
        waited = 0;
        @(negedge clk);
        while (expect_q.size() != 0 || out_valid) begin
            if (waited >= 1000) begin
                abort_run("retirement records still missing at end of test");
            end
            waited++;
            @(negedge clk);
        end
        @(posedge clk);
        #1;
        $display("%-26s %0d checks, %0d errors", name, check_count - test_checks,
                 error_count - test_errors);
        test_checks = check_count;
        test_errors = error_count;
    endtask

    initial begin : compare_proc
        v850_core_pkg::retire_t want;
        out_ready = 1'b1;
        forever begin
            @(posedge clk);
            #1;
            bp_seed   = lcg_step(bp_seed);
            out_ready = bp_enable ? bp_seed[27] : 1'b1;
            @(negedge clk);
            if (!reset && out_valid && out_ready) begin
                if (expect_q.size() == 0) begin
                    error_count++;
                    $display("A record retired with no instruction pending");
                end else begin
                    want = expect_q.pop_front();
                    check_value("out_dest", 32'(out_dest), 32'(want.dest));
                    check_value("out_write", 32'(out_write), 32'(want.write));
                    if (want.write) begin  // Data defined only when written
                        check_value("out_data", out_data, want.data);
                    end
                    check_value("out_flags", 32'(out_flags), 32'(want.flags));
                end
            end
        end
    end

    initial begin : stimulus_proc
        logic [4:0]  rd;
        logic [4:0]  prev;
        logic [5:0]  opc;
        logic [31:0] r;
        stim_seed   = 32'hf761_d5e5;
        bp_seed     = ~stim_seed;
        bp_enable   = 1'b0;
        check_count = 0;
        error_count = 0;
        test_checks = 0;
        test_errors = 0;
        reset       = 1'b1;
        in_valid    = 1'b0;
        in_insn     = '0;
        model_clear();
        repeat (8) @(posedge clk);
        #1;
        reset = 1'b0;

        for (int i = 1; i < 32; i++) begin
            send_insn(encode(5'(i), v850_isa_pkg::op_mov_imm, rand5()));
        end
        send_insn(encode(5'd0, v850_isa_pkg::op_mov_imm, rand5()));  // r0, no write
        finish_test("1 immediate loads");

        for (int i = 1; i < 32; i++) begin  // Build full 32-bit values
            send_insn(encode(5'(i), v850_isa_pkg::op_mov_imm, rand5()));
            repeat (6) begin
                send_insn(encode(5'(i), v850_isa_pkg::op_shl_imm, 5'd5));
                send_insn(encode(5'(i), v850_isa_pkg::op_add_imm, rand5()));
            end
        end
        for (int i = 0; i < 300; i++) begin
            send_insn(encode(rand5(), alu_ops[3'(rand5())], rand5()));
        end
        finish_test("2 register operations");

        for (int i = 0; i < 60; i++) begin
            rd = rand_reg_nz();
            opc = (i % 3 == 0) ? v850_isa_pkg::op_cmp :
                  (i % 3 == 1) ? v850_isa_pkg::op_cmp_imm : v850_isa_pkg::op_tst;
            send_insn(encode(rd, opc, rand5()));
            send_insn(encode(rd, v850_isa_pkg::op_mov, rd));  // Value must be unchanged
        end
        finish_test("3 compare and test");

        for (int n = 0; n < 32; n++) begin
            for (int k = 0; k < 3; k++) begin
                rd = rand_reg_nz();
                opc = (k == 0) ? v850_isa_pkg::op_shl_imm :
                      (k == 1) ? v850_isa_pkg::op_shr_imm : v850_isa_pkg::op_sar_imm;
                send_insn(encode(rd, v850_isa_pkg::op_xor, rand5()));  // Refresh the bits
                send_insn(encode(rd, opc, 5'(n)));
            end
        end
        finish_test("4 shifts");

        prev = rand_reg_nz();
        for (int i = 0; i < 200; i++) begin  // One per cycle, each reads the last dest
            opc = all_ops[4'(rand5())];
            rd  = rand_reg_nz();
            if (opc[4]) begin
                send_insn(encode(prev, opc, rand5()));  // Format II reads reg2
            end else begin
                send_insn(encode(rd, opc, prev));
                prev = rd;
            end
        end
        finish_test("5 dependent stream");

        bp_enable = 1'b1;
        for (int i = 0; i < 300; i++) begin
            stim_seed = lcg_step(stim_seed);
            r = stim_seed;
            opc = all_ops[r[27:24]];
            if (r[31:29] < 3'd2) begin
                opc = r[23:18];
                if (opcode_known(opc)) begin
                    opc = 6'b111111;  // Unsupported for sure
                end
            end
            if (r[17:16] == 2'd0) begin  // Random gap on the input side
                @(posedge clk);
                #1;
            end
            send_insn(encode(rand5(), opc, rand5()));
        end
        finish_test("6 back-pressure, no-ops");
        bp_enable = 1'b0;

        $display("Total: %0d checks, %0d errors", check_count, error_count);
        if (error_count == 0 && check_count > 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

// ==== vlog.f ====
+incdir+logic
+incdir+dv
logic/v850_isa_pkg.sv
logic/v850_core_pkg.sv
logic/v850_ifs.sv
logic/v850_regfile.sv
logic/v850_decoder.sv
logic/v850_execute.sv
logic/v850_core.sv
dv/v850_tb.sv

// ==== Makefile ====
run: obj_dir/Vv850_tb
	obj_dir/Vv850_tb > sim.log; cat sim.log
	grep -qx "Test OK" sim.log

obj_dir/Vv850_tb: vlog.f $(wildcard logic/*.sv logic/*.svh dv/*.sv dv/*.svh)
	verilator --binary --timing --top-module v850_tb -f vlog.f -o Vv850_tb

clean:
	rm -rf obj_dir sim.log

.PHONY: run clean
